//--- build.f
+incdir+hdl
hdl/cin_link_pkg.sv
hdl/cin_regs_pkg.sv
hdl/cin_wb_decode.sv
hdl/cin_cmd_sequencer.sv
hdl/cin_serializer.sv
hdl/cin_status.sv
hdl/cin_link_top.sv
verif/cin_link_tb.sv

//--- Bender.yml
package:
  name: cin_link

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cin_link_pkg.sv
      - hdl/cin_regs_pkg.sv
      - hdl/cin_wb_decode.sv
      - hdl/cin_cmd_sequencer.sv
      - hdl/cin_serializer.sv
      - hdl/cin_status.sv
      - hdl/cin_link_top.sv
      - target: test
        files:
          - verif/cin_link_tb.sv

//--- verif/cin_link_tb.sv
`include "cin_cfg.svh"

module cin_link_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 2000;  // About 50 words plus register traffic, with margin.
    localparam logic [2:0] ADR_CTRL        = 3'd0;
    localparam logic [2:0] ADR_CMD         = 3'd1;
    localparam logic [2:0] ADR_STATUS      = 3'd2;
    localparam logic [2:0] ADR_CMD_COUNT   = 3'd3;
    localparam logic [2:0] ADR_TRAIN_COUNT = 3'd4;
    localparam logic [2:0] ADR_LAST_CMD    = 3'd5;

    logic        sysclk = 1'b0;
    logic        rst, sync, wb_cyc, wb_stb, wb_we, wb_ack;
    logic [2:0]  wb_adr;
    logic [31:0] wb_wdata, wb_rdata;
    logic [3:0]  cin_nibble;

    // Link model. The phase and the holding queue follow the load rule of the link.
    logic [2:0]  phase = 3'd0;
    logic        model_train = 1'b0;
    logic [31:0] pend_q[$];
    logic        inc_valid = 1'b0;  // Accepted command, visible one edge after its ack.
    logic [31:0] inc_word;
    logic [15:0] cmd_count = '0, train_count = '0;
    logic [31:0] last_cmd = '0;
    logic        snap_train, snap_pending;  // Model state in the cycle before the last edge.
    logic [15:0] snap_cmd_count, snap_train_count;
    logic [31:0] snap_last_cmd;
    logic [31:0] exp_word, got_word, rnd_state;
    logic        exp_is_cmd, collecting = 1'b0;
    int          nib_idx, words_checked = 0, cmd_checked = 0, cmd_accepted = 0;
    int          checks = 0, errors = 0, cycles = 0;

    cin_link_top u_cin_link_top (
        .sysclk_i(sysclk), .rst_i(rst), .sync_i(sync),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_wdata), .wb_dat_o(wb_rdata), .wb_ack_o(wb_ack), .cin_nibble_o(cin_nibble)
    );

    always #10 sysclk = ~sysclk;

    // Expected word for one load slot. Training wins over a pending command.
    function automatic logic [31:0] ref_word(input logic train, input logic pending,
                                             input logic [31:0] cmd);
        if (train) return `CIN_TRAIN_VALUE;
        if (pending) return cmd;
        return 32'h0;
    endfunction

    function automatic logic [31:0] ref_reg(input logic [2:0] adr);
        case (adr)
            ADR_CTRL:        return {31'b0, snap_train};
            ADR_STATUS:      return {30'b0, snap_train, snap_pending};
            ADR_CMD_COUNT:   return {16'b0, snap_cmd_count};
            ADR_TRAIN_COUNT: return {16'b0, snap_train_count};
            ADR_LAST_CMD:    return snap_last_cmd;
            default:         return 32'h0;  // REG_CMD and unmapped addresses.
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge sysclk) begin : link_model
        logic [31:0] head;
        snap_train       = model_train;
        snap_pending     = (pend_q.size() != 0);
        snap_cmd_count   = cmd_count;
        snap_train_count = train_count;
        snap_last_cmd    = last_cmd;
        if (rst) begin
            phase = 3'd0;
        end else begin
            if (phase == 3'd7) begin  // Load edge.
                head       = snap_pending ? pend_q[0] : 32'h0;
                exp_word   = ref_word(model_train, snap_pending, head);
                exp_is_cmd = !model_train && snap_pending;
                if (model_train) train_count = train_count + 16'd1;
                if (exp_is_cmd) begin
                    cmd_count = cmd_count + 16'd1;
                    last_cmd  = pend_q.pop_front();
                end
                collecting = 1'b1;
                nib_idx    = 0;
            end
            phase = sync ? 3'd1 : phase + 3'd1;
            if (sync) collecting = 1'b0;  // A word cut short by realignment is dropped.
        end
        if (inc_valid) begin
            pend_q.push_back(inc_word);
            inc_valid = 1'b0;
        end
    end

    // Nibble monitor and word compare.
    always @(negedge sysclk) begin
        if (collecting) begin
            got_word[nib_idx*4 +: 4] = cin_nibble;
            nib_idx = nib_idx + 1;
            if (nib_idx == `CIN_NIBBLES) begin
                collecting    = 1'b0;
                checks        = checks + 1;
                words_checked = words_checked + 1;
                if (got_word !== exp_word) begin
                    errors = errors + 1;
                    $display("Mismatch at %0t: cin_nibble_o word expected %08h, got %08h",
                             $time, exp_word, got_word);
                end
                if (exp_is_cmd) cmd_checked = cmd_checked + 1;
            end
        end
    end

    always @(posedge sysclk) cycles <= cycles + 1;

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("Timeout: the run reached the limit of %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    // Holds the request until ack. Without back-pressure ack comes in the second cycle.
    task automatic wait_ack(input logic may_stall);
        int waited;
        waited = 0;
        do begin
            @(negedge sysclk);
            waited = waited + 1;
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!may_stall) begin
            checks = checks + 1;
            if (waited != 1) begin
                errors = errors + 1;
                $display("Mismatch at %0t: wb_ack_o latency expected 1 cycle, got %0d",
                         $time, waited);
            end
        end
    endtask

    // Ack lasts exactly one cycle.
    task automatic check_ack_released();
        @(negedge sysclk);
        checks = checks + 1;
        if (wb_ack !== 1'b0) begin
            errors = errors + 1;
            $display("Mismatch at %0t: wb_ack_o one cycle after ack expected 0, got %b",
                     $time, wb_ack);
        end
    endtask

    task automatic bus_write(input logic [2:0] adr, input logic [31:0] data);
        logic may_stall;
        may_stall = (adr == ADR_CMD) && (pend_q.size() != 0);  // Held until that load.
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_wdata = data;
        wait_ack(may_stall);
        if (adr == ADR_CTRL) model_train = data[0];
        if (adr == ADR_CMD) begin
            checks = checks + 1;
            if (pend_q.size() != 0) begin
                errors = errors + 1;
                $display("At %0t a REG_CMD write was acknowledged while a command was pending",
                         $time);
            end
            inc_valid    = 1'b1;
            inc_word     = data;
            cmd_accepted = cmd_accepted + 1;
        end
        check_ack_released();
    endtask

    task automatic bus_read(input logic [2:0] adr);
        logic [31:0] exp;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack(1'b0);
        exp    = ref_reg(adr);
        checks = checks + 1;
        if (wb_rdata !== exp) begin
            errors = errors + 1;
            $display("Mismatch at %0t: wb_dat_o (address %0d) expected %08h, got %08h",
                     $time, adr, exp, wb_rdata);
        end
        check_ack_released();
    endtask

    task automatic wait_words(input int n);
        int target;
        target = words_checked + n;
        while (words_checked < target) @(negedge sysclk);
    endtask

    task automatic wait_drained();
        while (cmd_checked != cmd_accepted) @(negedge sysclk);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) $display("Test %s: done, no errors", name);
        else $display("Test %s: done, %0d errors", name, errors - err_before);
    endtask

    initial begin
        int          err0;
        logic [31:0] first;
        rst      = 1'b1;
        sync     = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 3'd0;
        wb_wdata = 32'h0;
        rnd_state = 32'h203e_33d4;
        repeat (4) @(posedge sysclk);
        @(negedge sysclk);
        rst  = 1'b0;
        sync = 1'b1;  // One pulse aligns the command phase.

        err0   = errors;
        checks = checks + 1;
        if (cin_nibble !== 4'h0) begin
            errors = errors + 1;
            $display("Mismatch at %0t: cin_nibble_o expected 0, got %h", $time, cin_nibble);
        end
        @(negedge sysclk);
        sync = 1'b0;
        for (int a = 0; a < 8; a++) bus_read(3'(a));
        wait_words(2);
        report_test("reset", err0);

        err0 = errors;
        for (int i = 0; i < 20; i++) begin
            rnd_state = xorshift32(rnd_state);
            bus_write(ADR_CMD, rnd_state);
            wait_drained();
        end
        report_test("random commands", err0);

        err0 = errors;
        bus_write(ADR_CTRL, 32'h1);
        rnd_state = xorshift32(rnd_state);
        bus_write(ADR_CMD, rnd_state);  // Held while training runs.
        wait_words(3);
        bus_read(ADR_STATUS);
        bus_read(ADR_CTRL);
        bus_write(ADR_CTRL, 32'h0);
        wait_drained();
        report_test("training", err0);

        err0 = errors;
        rnd_state = xorshift32(rnd_state);
        first     = rnd_state;
        rnd_state = xorshift32(rnd_state);
        bus_write(ADR_CMD, first);
        bus_write(ADR_CMD, rnd_state);  // Must stall until the first one is loaded.
        wait_drained();
        report_test("back-pressure", err0);

        err0 = errors;
        bus_read(ADR_CMD_COUNT);
        bus_read(ADR_TRAIN_COUNT);
        bus_read(ADR_LAST_CMD);
        bus_read(ADR_STATUS);
        bus_write(ADR_LAST_CMD, 32'hFFFF_FFFF);  // Read-only, so nothing changes.
        bus_read(ADR_LAST_CMD);
        bus_read(ADR_CMD);
        report_test("status registers", err0);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- hdl/cin_link_top.sv
`include "cin_cfg.svh"

module cin_link_top (
    input  logic                   sysclk_i,
    input  logic                   rst_i,
    input  logic                   sync_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [2:0]             wb_adr_i,
    input  logic [`CIN_WORD_W-1:0] wb_dat_i,
    output logic [`CIN_WORD_W-1:0] wb_dat_o,
    output logic                   wb_ack_o,
    output logic [3:0]             cin_nibble_o
);
    import cin_link_pkg::*;

    logic                   train_en;
    logic                   cmd_wr;
    logic [`CIN_WORD_W-1:0] cmd_data;
    logic                   cmd_pending;
    logic                   load_req;
    logic [`CIN_WORD_W-1:0] load_word;
    logic                   sent_valid;
    word_kind_e             sent_kind;
    logic [`CIN_WORD_W-1:0] sent_word;
    logic [`CIN_CNT_W-1:0]  cmd_count;
    logic [`CIN_CNT_W-1:0]  train_count;
    logic [`CIN_WORD_W-1:0] last_cmd;

    cin_wb_decode u_decode (
        .sysclk_i, .rst_i,
        .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
        .cmd_pending_i(cmd_pending), .cmd_count_i(cmd_count),
        .train_count_i(train_count), .last_cmd_i(last_cmd),
        .train_en_o(train_en), .cmd_wr_o(cmd_wr), .cmd_data_o(cmd_data)
    );

    cin_cmd_sequencer u_sequencer (
        .sysclk_i, .rst_i,
        .train_en_i(train_en), .cmd_wr_i(cmd_wr), .cmd_data_i(cmd_data),
        .load_req_i(load_req), .cmd_pending_o(cmd_pending), .load_word_o(load_word),
        .sent_valid_o(sent_valid), .sent_kind_o(sent_kind), .sent_word_o(sent_word)
    );

    // Only this block sees the link timing; everything else follows load_req.
    cin_serializer u_serializer (
        .sysclk_i, .rst_i, .sync_i,
        .load_word_i(load_word), .load_req_o(load_req), .cin_nibble_o
    );

    cin_status u_status (
        .sysclk_i, .rst_i,
        .sent_valid_i(sent_valid), .sent_kind_i(sent_kind), .sent_word_i(sent_word),
        .cmd_count_o(cmd_count), .train_count_o(train_count), .last_cmd_o(last_cmd)
    );

endmodule

//--- hdl/cin_status.sv
`include "cin_cfg.svh"

module cin_status (
    input  logic                     sysclk_i,
    input  logic                     rst_i,
    input  logic                     sent_valid_i,
    input  cin_link_pkg::word_kind_e sent_kind_i,
    input  logic [`CIN_WORD_W-1:0]   sent_word_i,
    output logic [`CIN_CNT_W-1:0]    cmd_count_o,
    output logic [`CIN_CNT_W-1:0]    train_count_o,
    output logic [`CIN_WORD_W-1:0]   last_cmd_o
);
    import cin_link_pkg::*;

    logic cmd_sent;
    logic train_sent;

    assign cmd_sent   = sent_valid_i && (sent_kind_i == KIND_CMD);
    assign train_sent = sent_valid_i && (sent_kind_i == KIND_TRAIN);

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            cmd_count_o   <= '0;
            train_count_o <= '0;
            last_cmd_o    <= '0;
        end else begin
            // Both counters stick at all ones instead of wrapping.
            if (cmd_sent && !(&cmd_count_o)) begin
                cmd_count_o <= cmd_count_o + 1'b1;
            end
            if (train_sent && !(&train_count_o)) begin
                train_count_o <= train_count_o + 1'b1;
            end
            if (cmd_sent) begin
                last_cmd_o <= sent_word_i;  // Training and idle words leave it alone.
            end
        end
    end

endmodule

//--- hdl/cin_serializer.sv
`include "cin_cfg.svh"

module cin_serializer (
    input  logic                   sysclk_i,
    input  logic                   rst_i,
    input  logic                   sync_i,
    input  logic [`CIN_WORD_W-1:0] load_word_i,
    output logic                   load_req_o,
    output logic [3:0]             cin_nibble_o
);
    localparam int PHASE_W = $clog2(`CIN_NIBBLES);

    logic [PHASE_W-1:0]     phase;
    logic [`CIN_WORD_W-1:0] shreg;

    // The last cycle of a phase fetches the word for the next one.
    assign load_req_o = (phase == PHASE_W'(`CIN_NIBBLES - 1));

    // Sync lands on phase 1, which puts the load edge 6 cycles later.
    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            phase <= '0;
        end else if (sync_i) begin
            phase <= PHASE_W'(1);
        end else begin
            phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            shreg <= '0;
        end else if (load_req_o) begin
            shreg <= load_word_i;
        end else begin
            shreg <= {4'b0000, shreg[`CIN_WORD_W-1:4]};  // Zeros fill from the top.
        end
    end

    // LSB nibble leaves first.
    assign cin_nibble_o = shreg[3:0];

endmodule

//--- hdl/cin_cmd_sequencer.sv
`include "cin_cfg.svh"

module cin_cmd_sequencer (
    input  logic                     sysclk_i,
    input  logic                     rst_i,
    input  logic                     train_en_i,
    input  logic                     cmd_wr_i,
    input  logic [`CIN_WORD_W-1:0]   cmd_data_i,
    input  logic                     load_req_i,
    output logic                     cmd_pending_o,
    output logic [`CIN_WORD_W-1:0]   load_word_o,
    output logic                     sent_valid_o,
    output cin_link_pkg::word_kind_e sent_kind_o,
    output logic [`CIN_WORD_W-1:0]   sent_word_o
);
    import cin_link_pkg::*;

    seq_state_e             state;
    logic [`CIN_WORD_W-1:0] cmd_hold;  // One-deep command holding register.
    logic                   cmd_load;

    assign cmd_pending_o = (state == SEQ_PENDING);

    // A pending command only goes out on a slot that training does not claim.
    assign cmd_load = load_req_i && !train_en_i && cmd_pending_o;

    // Word selection for the next command phase.
    always_comb begin
        if (train_en_i) begin
            load_word_o = `CIN_TRAIN_VALUE;
            sent_kind_o = KIND_TRAIN;
        end else if (cmd_pending_o) begin
            load_word_o = cmd_hold;
            sent_kind_o = KIND_CMD;
        end else begin
            load_word_o = '0;
            sent_kind_o = KIND_IDLE;
        end
    end

    assign sent_valid_o = load_req_i;  // Every load is reported, idle included.
    assign sent_word_o  = load_word_o;

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            state <= SEQ_EMPTY;
        end else begin
            case (state)
                SEQ_EMPTY: begin
                    if (cmd_wr_i) state <= SEQ_PENDING;
                end
                SEQ_PENDING: begin
                    if (cmd_load) state <= SEQ_EMPTY;
                end
                default: state <= SEQ_EMPTY;
            endcase
        end
    end

    // The decode block never writes while a command is pending,
    // so the holding register cannot be overwritten before it is sent.
    always_ff @(posedge sysclk_i) begin
        if (cmd_wr_i) begin
            cmd_hold <= cmd_data_i;
        end
    end

endmodule

//--- hdl/cin_wb_decode.sv
`include "cin_cfg.svh"

module cin_wb_decode (
    input  logic                   sysclk_i,
    input  logic                   rst_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [2:0]             wb_adr_i,
    input  logic [`CIN_WORD_W-1:0] wb_dat_i,
    input  logic                   cmd_pending_i,
    input  logic [`CIN_CNT_W-1:0]  cmd_count_i,
    input  logic [`CIN_CNT_W-1:0]  train_count_i,
    input  logic [`CIN_WORD_W-1:0] last_cmd_i,
    output logic [`CIN_WORD_W-1:0] wb_dat_o,
    output logic                   wb_ack_o,
    output logic                   train_en_o,
    output logic                   cmd_wr_o,
    output logic [`CIN_WORD_W-1:0] cmd_data_o
);
    import cin_regs_pkg::*;

    reg_addr_e              addr;
    logic                   req;
    logic                   cmd_req;
    logic                   accept;
    logic [`CIN_WORD_W-1:0] rd_data;

    assign addr = reg_addr_e'(wb_adr_i);

    // The ack cycle itself must not start a second access.
    assign req     = wb_cyc_i && wb_stb_i && !wb_ack_o;
    assign cmd_req = req && wb_we_i && (addr == REG_CMD);

    // A command write waits here until the holding register is free.
    assign accept = req && !(cmd_req && cmd_pending_i);

    always_comb begin
        rd_data = '0;
        case (addr)
            REG_CTRL: rd_data[CTRL_TRAIN_BIT] = train_en_o;
            REG_STATUS: begin
                rd_data[STATUS_PENDING_BIT] = cmd_pending_i;
                rd_data[STATUS_TRAIN_BIT]   = train_en_o;
            end
            REG_CMD_COUNT:   rd_data[`CIN_CNT_W-1:0] = cmd_count_i;
            REG_TRAIN_COUNT: rd_data[`CIN_CNT_W-1:0] = train_count_i;
            REG_LAST_CMD:    rd_data = last_cmd_i;
            default: ;  // REG_CMD and unmapped addresses read as zero.
        endcase
    end

    always_ff @(posedge sysclk_i) begin
        if (rst_i) begin
            wb_ack_o   <= 1'b0;
            train_en_o <= 1'b0;
            cmd_wr_o   <= 1'b0;
        end else begin
            wb_ack_o <= accept;
            cmd_wr_o <= accept && cmd_req;  // Lines up with the ack.
            if (accept && wb_we_i && (addr == REG_CTRL)) begin
                train_en_o <= wb_dat_i[CTRL_TRAIN_BIT];
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (accept && cmd_req) begin
            cmd_data_o <= wb_dat_i;
        end
        // Read data is only meaningful while ack is high.
        wb_dat_o <= (accept && !wb_we_i) ? rd_data : '0;
    end

endmodule

//--- hdl/cin_regs_pkg.sv
// Register map seen by the host through the Wishbone slave.
package cin_regs_pkg;

    // Word addresses. Addresses 6 and 7 are unmapped and read as zero.
    typedef enum logic [2:0] {
        REG_CTRL        = 3'd0,  // Read/write control bits.
        REG_CMD         = 3'd1,  // Write-only command queue entry.
        REG_STATUS      = 3'd2,  // Read-only live status.
        REG_CMD_COUNT   = 3'd3,  // Read-only count of commands sent.
        REG_TRAIN_COUNT = 3'd4,  // Read-only count of training words sent.
        REG_LAST_CMD    = 3'd5   // Read-only copy of the last command sent.
    } reg_addr_e;

    // Bit in REG_CTRL that turns the training pattern on.
    localparam int CTRL_TRAIN_BIT = 0;

    // Bits of REG_STATUS.
    localparam int STATUS_PENDING_BIT = 0;  // A command is waiting.
    localparam int STATUS_TRAIN_BIT   = 1;  // Training is enabled.

endpackage

//--- hdl/cin_link_pkg.sv
// Types shared along the word path of the link, from the sequencer
// to the serializer and the status block.
package cin_link_pkg;

    // Holding state of the one-deep command register.
    typedef enum logic {
        SEQ_EMPTY   = 1'b0,  // No command waiting.
        SEQ_PENDING = 1'b1   // A command waits for its load slot.
    } seq_state_e;

    // What the sequencer handed to the serializer at a load.
    // Idle words are all zero and carry no information.
    typedef enum logic [1:0] {
        KIND_IDLE  = 2'd0,
        KIND_TRAIN = 2'd1,
        KIND_CMD   = 2'd2
    } word_kind_e;

    // The value 3 is never produced by the sequencer.
    // The status block treats it like an idle word.

endpackage

//--- hdl/cin_cfg.svh
`ifndef CIN_CFG_SVH
`define CIN_CFG_SVH

// Build-time configuration of the command link.
// Every module that sizes a port from these values includes this file.

// Width of one command word, and of the Wishbone data bus.
`define CIN_WORD_W 32

// Nibbles per word. The link sends one nibble per sysclk_i cycle,
// so this is also the length of a command phase in cycles.
`define CIN_NIBBLES 8

// Word sent while training is enabled. The receiver uses it to find
// the word boundary and to center its sampling point.
`define CIN_TRAIN_VALUE 32'hA55A6996

// Width of the sent-word counters in the status block.
// They saturate at all ones.
`define CIN_CNT_W 16

`endif
